//--- flist.f
+incdir+verilog
verilog/lb_pkg.sv
verilog/led_timebase.sv
verilog/lb_write_decode.sv
verilog/led_pwm_channel.sv
verilog/lb_mirror_ram.sv
verilog/lb_config_rom.sv
verilog/lb_read_pipe.sv
verilog/lb_slave_top.sv
sim/lb_slave_tb.sv

//--- sim/lb_slave_tb.sv
// Testbench for the local-bus register slave
// Random bus traffic from a fixed seed against a register model,
// fixed-latency read checks and PWM duty measurement on every LED
`timescale 1ns/10ps
`include "lb_consts.svh"

module lb_slave_tb
	import lb_pkg::*;
();

	localparam int N_WR       = 400;
	localparam int LEN_RESET  = 40;
	localparam int LEN_MIRROR = 32 + 3 * N_WR;
	localparam int LEN_MAP    = 320;
	localparam int LEN_STATUS = 320;
	localparam int LEN_PWM    = `LB_N_LED + 3 * 1024 + 16;
	localparam int MAX_CYCLES = LEN_RESET + LEN_MIRROR + LEN_MAP + LEN_STATUS + LEN_PWM + 2000;

	logic                 clk;
	logic                 rst_n;
	logic                 control_strobe;
	logic                 control_rd;
	lb_addr_t             addr;
	lb_data_t             data_out;
	logic                 xdomain_fault;
	logic                 tx_mac_done;
	logic [15:0]          rx_mac_data;
	logic [1:0]           rx_mac_buf_status;
	lb_data_t             data_in;
	logic                 led_user_mode;
	logic                 rx_mac_hbank;
	logic [`LB_N_LED-1:0] led;

	// Register model
	lb_data_t    mirror_model [0:31];
	duty_t       duty_model [0:7];
	logic        user_model;
	logic        hbank_model;
	logic [15:0] fault_model;

	// Expected reads, stage 1 is due on data_in now
	logic        exp_valid [0:1];
	lb_data_t    exp_data [0:1];

	integer      seed;
	int          cycles;
	int          edges;
	logic        status_on;
	logic        failed;

	lb_slave_top dut_i (
		.clk(clk), .rst_n(rst_n), .control_strobe(control_strobe), .control_rd(control_rd),
		.addr(addr), .data_out(data_out), .xdomain_fault(xdomain_fault),
		.tx_mac_done(tx_mac_done), .rx_mac_data(rx_mac_data),
		.rx_mac_buf_status(rx_mac_buf_status), .data_in(data_in),
		.led_user_mode(led_user_mode), .rx_mac_hbank(rx_mac_hbank), .led(led)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Edge count out of reset feeds the uptime model, cycles bound the run
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (rst_n)
			edges = edges + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			fail_stop();
		end
	end

	task automatic fail_stop();
		failed = 1'b1;
		$display("Test failures found");
		$fatal(1, "stopped at first error");
	endtask

	// Status bank as seen on the strobe edge
	function automatic lb_data_t bank_expect(input logic [3:0] idx);
		case (idx)
			4'h0: return "Hell";
			4'h1: return "o wo";
			4'h2: return "rld!";
			4'h3: return "(::)";
			4'h4: return {16'h0, fault_model};
			// Input held since the previous negedge, sampled one edge early
			4'h6: return {31'h0, tx_mac_done};
			4'h7: return {30'h0, rx_mac_buf_status};
			// Tick one edge after the wrap, uptime one edge after that
			4'h8: return (edges == 0) ? '0 : lb_data_t'((edges - 1) / 1024);
			default: return `LB_BANK_DEFAULT;
		endcase
	endfunction

	function automatic lb_data_t expected_read(input lb_addr_t a, input logic [15:0] rxd);
		if (a[11])
			return {16'h0, 16'(a[10:0]) ^ `LB_ROM_SEED};
		case (a[23:16])
			8'h00: return mirror_model[a[4:0]];
			8'h03: return {16'h0, rxd};
			8'h11: return bank_expect(a[3:0]);
			8'h12: return (a[2:0] < `LB_N_LED) ? {24'h0, duty_model[a[2:0]]} : '0;
			default: return `LB_BAD_DATA;
		endcase
	endfunction

	// One bus cycle, driven on the falling edge
	task automatic bus_cycle(input logic strobe, input logic rd, input lb_addr_t a,
		input lb_data_t wd);
		logic [15:0] rxd;
		lb_data_t    expv;
		@(negedge clk);
		if (exp_valid[1]) begin
			assert (data_in === exp_data[1]) else begin
				$display("mismatch at %0t: data_in %h, expected %h", $time, data_in, exp_data[1]);
				fail_stop();
			end
		end
		assert (led_user_mode === user_model && rx_mac_hbank === hbank_model) else begin
			$display("mismatch at %0t: user_mode %b hbank %b, expected %b %b", $time,
				led_user_mode, rx_mac_hbank, user_model, hbank_model);
			fail_stop();
		end
		rxd = 16'($random(seed));
		// Fault driven last cycle was counted by the edge just past
		fault_model = fault_model + 16'(xdomain_fault);
		expv = expected_read(a, rxd);
		exp_valid[1] = exp_valid[0];
		exp_data[1] = exp_data[0];
		exp_valid[0] = strobe & rd;
		exp_data[0] = expv;
		// Local write lands on the coming edge
		if (strobe && !rd && a[23:16] == 8'h00) begin
			mirror_model[a[4:0]] = wd;
			if (a[3:0] == 4'd1)
				user_model = wd[0];
			if (a[3:0] == 4'd5)
				hbank_model = wd[0];
			if (a[3:0] >= 4'd8 && a[3:0] < 4'(8 + `LB_N_LED))
				duty_model[a[2:0]] = wd[7:0];
		end
		control_strobe = strobe;
		control_rd = rd;
		addr = a;
		data_out = wd;
		rx_mac_data = rxd;
		xdomain_fault = status_on && (($random(seed) & 7) == 0);
		if (status_on) begin
			tx_mac_done = 1'($random(seed));
			rx_mac_buf_status = 2'($random(seed));
		end
	endtask

	task automatic idle(input int n);
		repeat (n) bus_cycle(1'b0, 1'b0, '0, '0);
	endtask

	initial begin : main
		lb_addr_t a;
		int       kind;
		int       n_rd;
		int       high_cnt [0:7];
		logic [3:0] status_idx [0:3];
		status_idx = '{4'h4, 4'h6, 4'h7, 4'h8};
		seed = 32'he6d2495b;
		cycles = 0;
		edges = 0;
		failed = 1'b0;
		status_on = 1'b0;
		rst_n = 1'b0;
		control_strobe = 1'b0;
		control_rd = 1'b0;
		addr = '0;
		data_out = '0;
		xdomain_fault = 1'b0;
		tx_mac_done = 1'b0;
		rx_mac_data = '0;
		rx_mac_buf_status = '0;
		user_model = 1'b0;
		hbank_model = 1'b1;
		fault_model = '0;
		exp_valid = '{1'b0, 1'b0};
		for (int k = 0; k < 8; k++)
			duty_model[k] = '0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;

		// Reset values
		assert (data_in === '0 && led === '0 && led_user_mode === 1'b0 && rx_mac_hbank === 1'b1)
		else begin
			$display("mismatch at %0t: outputs not at reset values", $time);
			fail_stop();
		end
		// Greeting and unused bank slots
		for (int i = 0; i < 16; i++)
			bus_cycle(1'b1, 1'b1, {8'h11, 12'h0, 4'(i)}, '0);

		// Fill the mirror, then random writes with region 00 reads
		for (int i = 0; i < 32; i++)
			bus_cycle(1'b1, 1'b0, {8'h00, 11'h0, 5'(i)}, lb_data_t'($random(seed)));
		for (int i = 0; i < N_WR; i++) begin
			a = {8'h00, 16'($random(seed))};
			bus_cycle(1'b1, 1'b0, a, lb_data_t'($random(seed)));
			n_rd = ($random(seed) & 32'h7fffffff) % 3;
			for (int j = 0; j < n_rd; j++) begin
				// Often the word just written
				if ($random(seed) & 1)
					a = {8'h00, 4'($random(seed)), 1'b0, 6'($random(seed)), a[4:0]};
				else
					a = {8'h00, 4'($random(seed)), 1'b0, 6'($random(seed)), 5'($random(seed))};
				bus_cycle(1'b1, 1'b1, a, '0);
			end
		end

		// Read map: ROM, rx data, duty readback, anything else with bit 11 clear
		for (int i = 0; i < 300; i++) begin
			kind = $random(seed) & 3;
			a = lb_addr_t'($random(seed));
			case (kind)
				0: a[11] = 1'b1;
				1: a = {8'h03, 4'(a), 1'b0, a[10:0]};
				2: a = {8'h12, 4'(a), 1'b0, a[10:0]};
				default: a[11] = 1'b0;
			endcase
			bus_cycle(1'b1, 1'b1, a, '0);
		end

		// Status inputs toggling, bank 4, 6, 7 and 8
		status_on = 1'b1;
		for (int i = 0; i < 300; i++) begin
			if ($random(seed) & 1)
				bus_cycle(1'b1, 1'b1, {8'h11, 12'h0, status_idx[$random(seed) & 3]}, '0);
			else
				idle(1);
		end
		status_on = 1'b0;
		idle(3);

		// PWM: random duties, settle two periods, count one period
		for (int k = 0; k < `LB_N_LED; k++)
			bus_cycle(1'b1, 1'b0, {8'h00, 12'h0, 4'(8 + k)}, lb_data_t'($random(seed)));
		idle(2048);
		for (int k = 0; k < 8; k++)
			high_cnt[k] = 0;
		for (int i = 0; i < 1024; i++) begin
			idle(1);
			for (int k = 0; k < `LB_N_LED; k++)
				high_cnt[k] = high_cnt[k] + int'(led[k]);
		end
		for (int k = 0; k < `LB_N_LED; k++) begin
			assert (high_cnt[k] == 4 * int'(duty_model[k])) else begin
				$display("mismatch at %0t: led %0d high %0d cycles, expected %0d", $time, k,
					high_cnt[k], 4 * int'(duty_model[k]));
				fail_stop();
			end
		end

		if (!failed) begin
			$display("All tests passed!");
			$finish;
		end else begin
			fail_stop();
		end
	end

endmodule

//--- verilog/lb_config_rom.sv
// 2K x 16 configuration ROM
// Filled at elaboration, word k holds k XOR the seed
// Output is registered one edge after the address
`timescale 1ns/10ps
`include "lb_consts.svh"

module lb_config_rom (
	input  logic                  clk,
	input  logic [`LB_ROM_AW-1:0] addr,
	output logic [15:0]           data
);

	logic [15:0] rom [0:(1 << `LB_ROM_AW)-1];

	// Contents from the fixed rule
	initial begin
		for (int i = 0; i < (1 << `LB_ROM_AW); i++) begin
			rom[i] = 16'(i) ^ `LB_ROM_SEED;
		end
	end

	always_ff @(posedge clk) begin
		data <= rom[addr];
	end

endmodule

//--- verilog/lb_consts.svh
// Shared constants for the local-bus register slave
// Include wherever address fields, channel count or ROM rule are needed
`ifndef LB_CONSTS_SVH
`define LB_CONSTS_SVH

// Number of LED PWM channels, 1 to 8
`define LB_N_LED 4

// Region field of the bus address
`define LB_REGION_MSB 23
`define LB_REGION_LSB 16
`define LB_REGION_MIRROR 8'h00
`define LB_REGION_RXMAC 8'h03
`define LB_REGION_BANK 8'h11
`define LB_REGION_DUTY 8'h12

// Addresses xxx800 to xxxfff select the config ROM
`define LB_ROM_SEL_BIT 11

// Local register indices
`define LB_IDX_LED_USER 4'd1
`define LB_IDX_HBANK 4'd5
`define LB_IDX_DUTY0 8

// Mirror and ROM geometry, ROM word k is k ^ seed
`define LB_MIRROR_AW 5
`define LB_ROM_AW 11
`define LB_ROM_SEED 16'hc3a5

// Read fill values
`define LB_BAD_DATA 32'hdeadbeef
`define LB_BANK_DEFAULT "zzzz"

`endif

//--- verilog/lb_mirror_ram.sv
// Mirror RAM of every local write
// One synchronous write port, one registered read port,
// read data is ready in the first read cycle
`timescale 1ns/10ps
`include "lb_consts.svh"

module lb_mirror_ram
	import lb_pkg::*;
(
	input  logic                     clk,
	input  logic                     we,
	input  logic [`LB_MIRROR_AW-1:0] waddr,
	input  lb_data_t                 wdata,
	input  logic [`LB_MIRROR_AW-1:0] raddr,
	output lb_data_t                 rdata
);

	lb_data_t mem [0:(1 << `LB_MIRROR_AW)-1];

	// Write port
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Registered read, every cycle
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

//--- verilog/lb_pkg.sv
// Types shared by the local-bus slave modules
// Import with lb_pkg::* in the module header
package lb_pkg;

	// 24-bit local bus address
	typedef logic [23:0] lb_addr_t;

	// 32-bit local bus data, both directions
	typedef logic [31:0] lb_data_t;

	// LED duty factor, scaled by four against the phase
	typedef logic [7:0] duty_t;

	// PWM phase, one period is 1024 cycles
	typedef logic [9:0] pwm_phase_t;

	// One bus cycle's request
	// strobe qualifies the cycle, rd picks read or write
	typedef struct packed {
		logic     strobe;
		logic     rd;
		lb_addr_t addr;
		lb_data_t wdata;
	} lb_req_t;

endpackage

//--- verilog/lb_read_pipe.sv
// Two-cycle pipelined read path of the bus slave
// First cycle latches the bank word and region values with the address,
// second cycle picks the result by region into data_in
// Also keeps the fault counter and the MAC status sync registers
`timescale 1ns/10ps
`include "lb_consts.svh"

module lb_read_pipe
	import lb_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  lb_req_t               req,
	input  logic                  xdomain_fault,
	input  logic                  tx_mac_done,
	input  logic [1:0]            rx_mac_buf_status,
	input  logic [15:0]           rx_mac_data,
	input  lb_data_t              uptime,
	input  lb_data_t              mirror_data,
	input  logic [15:0]           rom_data,
	input  duty_t [`LB_N_LED-1:0] duty,
	output lb_data_t              data_in
);

	logic        do_rd;
	logic        do_rd_r;
	lb_addr_t    addr_r;
	logic [15:0] fault_count;
	logic        tx_mac_done_r;
	logic [1:0]  rx_mac_buf_status_r;
	lb_data_t    bank_word;
	logic [15:0] rx_data_r;
	duty_t       sel_duty;
	duty_t       duty_r;

	assign do_rd = req.strobe & req.rd;

	// Fault counter, clk is already the right domain
	// a burst at startup is expected
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fault_count <= '0;
		end else if (xdomain_fault) begin
			fault_count <= fault_count + 16'd1;
		end
	end

	// One-edge copies pin the MAC status to this clock
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_mac_done_r       <= 1'b0;
			rx_mac_buf_status_r <= '0;
		end else begin
			tx_mac_done_r       <= tx_mac_done;
			rx_mac_buf_status_r <= rx_mac_buf_status;
		end
	end

	// Duty of channel addr[2:0], zero when absent
	always_comb begin
		sel_duty = '0;
		for (int k = 0; k < `LB_N_LED; k++) begin
			if (req.addr[2:0] == 3'(k)) begin
				sel_duty = duty[k];
			end
		end
	end

	// First read cycle
	always_ff @(posedge clk) begin
		if (do_rd) begin
			case (req.addr[3:0])
				4'h0: bank_word <= "Hell";
				4'h1: bank_word <= "o wo";
				4'h2: bank_word <= "rld!";
				4'h3: bank_word <= "(::)";
				4'h4: bank_word <= {16'b0, fault_count};
				4'h6: bank_word <= {31'b0, tx_mac_done_r};
				4'h7: bank_word <= {30'b0, rx_mac_buf_status_r};
				4'h8: bank_word <= uptime;
				default: bank_word <= `LB_BANK_DEFAULT;
			endcase
			rx_data_r <= rx_mac_data;
			duty_r    <= sel_duty;
		end
	end

	// Address follows every cycle, the flag carries the read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			do_rd_r <= 1'b0;
		end else begin
			do_rd_r <= do_rd;
		end
	end

	always_ff @(posedge clk) begin
		addr_r <= req.addr;
	end

	// Second read cycle, ROM window wins over the region
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_in <= '0;
		end else if (do_rd_r) begin
			if (addr_r[`LB_ROM_SEL_BIT]) begin
				data_in <= {16'b0, rom_data};
			end else begin
				case (addr_r[`LB_REGION_MSB:`LB_REGION_LSB])
					`LB_REGION_MIRROR: data_in <= mirror_data;
					`LB_REGION_RXMAC:  data_in <= {16'b0, rx_data_r};
					`LB_REGION_BANK:   data_in <= bank_word;
					`LB_REGION_DUTY:   data_in <= {24'b0, duty_r};
					default:           data_in <= `LB_BAD_DATA;
				endcase
			end
		end
	end

	// Master must drive the control pair cleanly out of reset
	a_ctrl_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		!$isunknown({req.strobe, req.rd})
	);

endmodule

//--- verilog/lb_slave_top.sv
// Local-bus register slave, top level
// Packs the bus into one request and wires the timebase, write decoder,
// mirror, ROM, LED channels and the read pipeline
`timescale 1ns/10ps
`include "lb_consts.svh"

module lb_slave_top
	import lb_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 control_strobe,
	input  logic                 control_rd,
	input  lb_addr_t             addr,
	input  lb_data_t             data_out,
	input  logic                 xdomain_fault,
	input  logic                 tx_mac_done,
	input  logic [15:0]          rx_mac_data,
	input  logic [1:0]           rx_mac_buf_status,
	output lb_data_t             data_in,
	output logic                 led_user_mode,
	output logic                 rx_mac_hbank,
	output logic [`LB_N_LED-1:0] led
);

	lb_req_t               req;
	pwm_phase_t            phase;
	lb_data_t              uptime;
	logic                  local_we;
	logic [`LB_N_LED-1:0]  duty_we;
	duty_t                 duty_wdata;
	duty_t [`LB_N_LED-1:0] duty;
	lb_data_t              mirror_data;
	logic [15:0]           rom_data;

	assign req = '{strobe: control_strobe, rd: control_rd, addr: addr, wdata: data_out};

	// Tick only advances uptime inside the timebase
	led_timebase timebase_i (
		.clk(clk), .rst_n(rst_n), .phase(phase), .tick(), .uptime(uptime)
	);

	lb_write_decode write_dec_i (
		.clk(clk), .rst_n(rst_n), .req(req),
		.local_we(local_we), .duty_we(duty_we), .duty_wdata(duty_wdata),
		.led_user_mode(led_user_mode), .rx_mac_hbank(rx_mac_hbank)
	);

	// Same address field for write and read
	lb_mirror_ram mirror_i (
		.clk(clk), .we(local_we),
		.waddr(req.addr[`LB_MIRROR_AW-1:0]), .wdata(req.wdata),
		.raddr(req.addr[`LB_MIRROR_AW-1:0]), .rdata(mirror_data)
	);

	lb_config_rom rom_i (
		.clk(clk), .addr(req.addr[`LB_ROM_AW-1:0]), .data(rom_data)
	);

	genvar k;
	generate
		for (k = 0; k < `LB_N_LED; k++) begin : g_led
			led_pwm_channel chan_i (
				.clk(clk), .rst_n(rst_n), .phase(phase),
				.duty_we(duty_we[k]), .duty_wdata(duty_wdata),
				.duty(duty[k]), .led(led[k])
			);
		end
	endgenerate

	lb_read_pipe read_pipe_i (
		.clk(clk), .rst_n(rst_n), .req(req),
		.xdomain_fault(xdomain_fault), .tx_mac_done(tx_mac_done),
		.rx_mac_buf_status(rx_mac_buf_status), .rx_mac_data(rx_mac_data),
		.uptime(uptime), .mirror_data(mirror_data), .rom_data(rom_data),
		.duty(duty), .data_in(data_in)
	);

endmodule

//--- verilog/lb_write_decode.sv
// Local write decoder for the bus slave
// Qualifies writes with region 00, holds the control registers,
// and fans out one-hot duty write enables to the LED channels
`timescale 1ns/10ps
`include "lb_consts.svh"

module lb_write_decode
	import lb_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  lb_req_t              req,
	output logic                 local_we,
	output logic [`LB_N_LED-1:0] duty_we,
	output duty_t                duty_wdata,
	output logic                 led_user_mode,
	output logic                 rx_mac_hbank
);

	logic [3:0] reg_idx;

	// Write cycle aimed at region 00
	assign local_we = req.strobe & ~req.rd &
		(req.addr[`LB_REGION_MSB:`LB_REGION_LSB] == '0);
	assign reg_idx = req.addr[3:0];

	// Duty value is the low byte of the write data
	assign duty_wdata = req.wdata[7:0];

	// Index 8+k enables channel k
	genvar k;
	generate
		for (k = 0; k < `LB_N_LED; k++) begin : g_duty_we
			assign duty_we[k] = local_we & (reg_idx == 4'(`LB_IDX_DUTY0 + k));
		end
	endgenerate

	// Control registers, hbank comes out of reset set
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			led_user_mode <= 1'b0;
			rx_mac_hbank  <= 1'b1;
		end else if (local_we) begin
			case (reg_idx)
				`LB_IDX_LED_USER: led_user_mode <= req.wdata[0];
				`LB_IDX_HBANK:    rx_mac_hbank  <= req.wdata[0];
				default: ;
			endcase
		end
	end

	// At most one channel loads per write
	a_duty_we_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(duty_we)
	);

endmodule

//--- verilog/led_pwm_channel.sv
// One LED PWM channel
// Holds an 8-bit duty and drives a registered output that is high
// while the shared phase is below four times the duty
`timescale 1ns/10ps

module led_pwm_channel
	import lb_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  pwm_phase_t phase,
	input  logic       duty_we,
	input  duty_t      duty_wdata,
	output duty_t      duty,
	output logic       led
);

	// Duty register, loaded from the write decoder
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			duty <= '0;
		end else if (duty_we) begin
			duty <= duty_wdata;
		end
	end

	// Compare against duty * 4, high for 4*duty cycles per period
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			led <= 1'b0;
		end else begin
			led <= (phase < {duty, 2'b00});
		end
	end

	// A zero duty keeps the LED dark on the next cycle
	a_zero_duty_dark: assert property (
		@(posedge clk) disable iff (!rst_n)
		(duty == '0) |=> !led
	);

endmodule

//--- verilog/led_timebase.sv
// Shared PWM timebase for all LED channels
// Free-running 10-bit phase, a tick on every wrap, and an uptime count of ticks
`timescale 1ns/10ps

module led_timebase
	import lb_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	output pwm_phase_t phase,
	output logic       tick,
	output lb_data_t   uptime
);

	// One bit wider than the phase so the carry falls out
	logic [10:0] phase_next;

	assign phase_next = {1'b0, phase} + 11'd1;

	// Phase counter, tick is the registered carry
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= '0;
			tick  <= 1'b0;
		end else begin
			{tick, phase} <= phase_next;
		end
	end

	// Uptime in whole PWM periods
	// wraps after about ten hours at 125 MHz
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			uptime <= '0;
		end else if (tick) begin
			uptime <= uptime + 32'd1;
		end
	end

endmodule
